// File: Bender.yml
package:
  name: ctx_load_microcode

sources:
  - files:
      - design/uop_pkg.sv
      - design/ctx_load_pkg.sv
      - design/ctx_load_rom.sv
      - design/ctx_load_microcode.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/ctx_load_checker.sv
      - dv/tb_ctx_load.sv

# Simulation top: tb_ctx_load
# Design top: ctx_load_microcode
# Test data read at run time: dv/ctx_load_cases.txt

// File: compile.f
design/uop_pkg.sv
design/ctx_load_pkg.sv
design/ctx_load_rom.sv
design/ctx_load_microcode.sv
dv/tb_clock_gen.sv
dv/ctx_load_checker.sv
dv/tb_ctx_load.sv

// File: design/ctx_load_microcode.sv
`timescale 1ns/100ps

module ctx_load_microcode
	import uop_pkg::*, ctx_load_pkg::*;
(
	input  logic             clk,
	input  logic             arst_n,
	input  logic [SEL_W-1:0] select,  // Pair index
	output uop_t             code0,   // Entry select*2
	output uop_t             code1    // Entry select*2+1
);

	logic               sel_valid;
	logic [ENTRY_W-1:0] entry_even;
	logic [ENTRY_W-1:0] entry_odd;
	uop_t               uop_even;
	uop_t               uop_odd;

	// Pair range check on the full select width
	assign sel_valid = (select < SEL_W'(CTX_LOAD_PAIRS));

	// Valid select fits in ENTRY_W-1 bits, so a shift is just a concat
	assign entry_even = sel_valid ? {select[ENTRY_W-2:0], 1'b0} : ENTRY_INVALID;
	assign entry_odd  = sel_valid ? {select[ENTRY_W-2:0], 1'b1} : ENTRY_INVALID;

	ctx_load_rom u_rom_even (
		.entry (entry_even),
		.uop   (uop_even)
	);

	ctx_load_rom u_rom_odd (
		.entry (entry_odd),
		.uop   (uop_odd)
	);

	// One cycle from select to code
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			code0 <= '0;  // wb_en and decode_error low
			code1 <= '0;
		end
		else
		begin
			code0 <= uop_even;
			code1 <= uop_odd;
		end
	end

endmodule

// File: design/ctx_load_pkg.sv
package ctx_load_pkg;

	// Program size
	localparam int unsigned CTX_LOAD_ENTRIES = 44;                    // Micro-ops in the program
	localparam int unsigned CTX_LOAD_PAIRS   = CTX_LOAD_ENTRIES / 2;  // 22 selectable pairs

	// Address widths
	localparam int unsigned ENTRY_W = 7;   // Entry number, room for the invalid code
	localparam int unsigned SEL_W   = 32;  // Pair select from the front end

	// Entry number forced onto both ROMs for an out of range select
	localparam logic [ENTRY_W-1:0] ENTRY_INVALID = 7'd127;

	// Stack pointer computation immediates
	localparam int unsigned TASK_BASE_OFFSET = 268;  // Offset of the saved frame in task info
	localparam int unsigned TASK_STRIDE      = 144;  // Bytes per task record

	// Program layout
	localparam int unsigned SYS_POP_FIRST = 6;                   // SSR0..SSR2 pops
	localparam int unsigned GPR_POP_FIRST = 9;                   // R31 pop, then down to R0
	localparam int unsigned GPR_POP_COUNT = 32;
	localparam int unsigned RESTORE_FIRST = GPR_POP_FIRST + GPR_POP_COUNT;  // Entry 41

	// What an entry number decodes to
	typedef enum logic [2:0] {
		KIND_COMPUTE = 3'd0,  // New stack pointer
		KIND_POP_SYS = 3'd1,  // Pop into a scratch system register
		KIND_POP_GPR = 3'd2,  // Pop into a general register
		KIND_RESTORE = 3'd3,  // PDTR, SPR and the jump
		KIND_INVALID = 3'd4   // Past the end of the program
	} entry_kind_e;

endpackage

// File: design/ctx_load_rom.sv
`timescale 1ns/100ps

module ctx_load_rom
	import uop_pkg::*, ctx_load_pkg::*;
(
	input  logic [ENTRY_W-1:0] entry,  // Program entry number
	output uop_t               uop     // Decoded micro-op
);

	entry_kind_e          kind;
	logic [ENTRY_W-1:0]   pop_dist;  // Distance from the first general pop
	logic [REG_IDX_W-1:0] gpr_dest;  // R31 down to R0

	// Range decode of the entry number
	always_comb
	begin
		if (entry < ENTRY_W'(SYS_POP_FIRST))
			kind = KIND_COMPUTE;
		else if (entry < ENTRY_W'(GPR_POP_FIRST))
			kind = KIND_POP_SYS;
		else if (entry < ENTRY_W'(RESTORE_FIRST))
			kind = KIND_POP_GPR;
		else if (entry < ENTRY_W'(CTX_LOAD_ENTRIES))
			kind = KIND_RESTORE;
		else
			kind = KIND_INVALID;
	end

	assign pop_dist = entry - ENTRY_W'(GPR_POP_FIRST);
	assign gpr_dest = {REG_IDX_W{1'b1}} - pop_dist[REG_IDX_W-1:0];  // Pops run R31 first

	always_comb
	begin
		uop = '0;  // Unlisted fields stay clear
		case (kind)
			KIND_COMPUTE:
			begin
				uop.src0_active = 1'b1;
				uop.wb_en       = 1'b1;
				case (entry)
					7'd0:  // R0 <= TISR
					begin
						uop.commit_wait = 1'b1;  // Serialize the system register read
						uop.src0        = SYSREG_TISR;
						uop.src0_sys    = 1'b1;
						uop.dest        = LREG_R0;
						uop.dest_rename = 1'b1;
						uop.cmd         = CMD_SYS_BUFFER;
						uop.unit        = EXE_SYS_REG;
					end
					7'd1:  // R0 <= R0 + 268
					begin
						uop.src0        = LREG_R0;
						uop.src1        = SRC1_W'(TASK_BASE_OFFSET);
						uop.src1_imm    = 1'b1;
						uop.src1_active = 1'b1;
						uop.dest        = LREG_R0;
						uop.dest_rename = 1'b1;
						uop.cmd         = CMD_ADD;
						uop.unit        = EXE_ADDER;
					end
					7'd2:  // R1 <= TIDR
					begin
						uop.commit_wait = 1'b1;
						uop.src0        = SYSREG_TIDR;
						uop.src0_sys    = 1'b1;
						uop.dest        = LREG_R1;
						uop.dest_rename = 1'b1;
						uop.cmd         = CMD_SYS_BUFFER;
						uop.unit        = EXE_SYS_REG;
					end
					7'd3:  // R1 <= R1 * 144
					begin
						uop.src0        = LREG_R1;
						uop.src1        = SRC1_W'(TASK_STRIDE);
						uop.src1_imm    = 1'b1;
						uop.src1_active = 1'b1;
						uop.dest        = LREG_R1;
						uop.dest_rename = 1'b1;
						uop.cmd         = CMD_MUL_LOW;
						uop.unit        = EXE_MUL;
					end
					7'd4:  // R0 <= R0 + R1
					begin
						uop.src0        = LREG_R0;
						uop.src1        = SRC1_W'(LREG_R1);  // Register number, not immediate
						uop.src1_active = 1'b1;
						uop.dest        = LREG_R0;
						uop.dest_rename = 1'b1;
						uop.cmd         = CMD_ADD;
						uop.unit        = EXE_ADDER;
					end
					default:  // Entry 5, SPR <= R0
					begin
						uop.src0     = LREG_R0;
						uop.dest     = SYSREG_SPR;
						uop.dest_sys = 1'b1;
						uop.cmd      = CMD_WRITE_SPR;
						uop.unit     = EXE_SYS_LDST;
					end
				endcase
			end
			KIND_POP_SYS, KIND_POP_GPR:
			begin
				// Every pop reads the stack through SPR
				uop.src1        = SRC1_W'(SYSREG_SPR);
				uop.src1_active = 1'b1;
				uop.src1_sys    = 1'b1;
				uop.wb_en       = 1'b1;
				uop.dest_rename = 1'b1;
				uop.cmd         = CMD_POP;
				uop.unit        = EXE_LDST;
				if (kind == KIND_POP_SYS)
				begin
					uop.dest_sys = 1'b1;
					case (entry)
						7'd6:    uop.dest = SYSREG_SSR0;  // Saved PDTR
						7'd7:    uop.dest = SYSREG_SSR1;  // Saved SPR
						default: uop.dest = SYSREG_SSR2;  // Saved PCR
					endcase
				end
				else
					uop.dest = gpr_dest;
			end
			KIND_RESTORE:
			begin
				case (entry)
					7'd41:  // PDTR <= SSR0
					begin
						uop.commit_wait = 1'b1;  // Address space switch
						uop.src0        = SYSREG_SSR0;
						uop.src0_active = 1'b1;
						uop.src0_sys    = 1'b1;
						uop.dest        = SYSREG_PDTR;
						uop.wb_en       = 1'b1;
						uop.dest_sys    = 1'b1;
						uop.cmd         = CMD_SYS_BUFFER;
						uop.unit        = EXE_SYS_REG;
					end
					7'd42:  // SPR <= SSR1
					begin
						uop.src0        = SYSREG_SSR1;
						uop.src0_active = 1'b1;
						uop.src0_sys    = 1'b1;
						uop.dest        = SYSREG_SPR;
						uop.wb_en       = 1'b1;
						uop.dest_sys    = 1'b1;
						uop.cmd         = CMD_WRITE_SPR;
						uop.unit        = EXE_SYS_LDST;
					end
					default:  // Entry 43, jump to SSR2
					begin
						uop.cond        = CC_ALWAYS;
						uop.src1        = SRC1_W'(SYSREG_SSR2);
						uop.src1_active = 1'b1;
						uop.src1_sys    = 1'b1;
						uop.dest        = SYSREG_PCR;
						uop.dest_sys    = 1'b1;  // No write back, branch unit owns PCR
						uop.cmd         = CMD_DJMP;
						uop.unit        = EXE_BRANCH;
					end
				endcase
			end
			default:
				uop.decode_error = 1'b1;  // Only this bit set
		endcase
	end

endmodule

// File: design/uop_pkg.sv
package uop_pkg;

	// Field widths of one decoded micro-op
	localparam int unsigned REG_IDX_W = 5;   // Logical or system register number
	localparam int unsigned SRC1_W    = 32;  // Immediate or register number
	localparam int unsigned COND_W    = 4;   // Condition code field

	// Execute unit select, low bits of the micro-op
	typedef enum logic [2:0] {
		EXE_SYS_REG  = 3'd0,  // System register buffer
		EXE_ADDER    = 3'd1,  // Integer adder
		EXE_MUL      = 3'd2,  // Multiplier
		EXE_SYS_LDST = 3'd3,  // System load/store, SPR writes
		EXE_LDST     = 3'd4,  // Load/store, stack pops
		EXE_BRANCH   = 3'd5   // Branch unit
	} exe_unit_e;

	// Unit commands, only the ones the context-load program issues
	typedef enum logic [4:0] {
		CMD_SYS_BUFFER = 5'd0,  // Pass source 0 through
		CMD_ADD        = 5'd1,  // src0 + src1
		CMD_MUL_LOW    = 5'd2,  // Low half of the product
		CMD_WRITE_SPR  = 5'd3,  // Stack pointer write
		CMD_POP        = 5'd4,  // Load from SPR, post increment
		CMD_DJMP       = 5'd5   // Direct jump to source 1
	} exe_cmd_e;

	// Condition codes
	localparam logic [COND_W-1:0] CC_NONE   = 4'h0;  // Unconditional, no flag use
	localparam logic [COND_W-1:0] CC_ALWAYS = 4'hf;  // Branch always

	// Logical registers
	localparam logic [REG_IDX_W-1:0] LREG_R0 = 5'd0;
	localparam logic [REG_IDX_W-1:0] LREG_R1 = 5'd1;

	// System registers
	localparam logic [REG_IDX_W-1:0] SYSREG_PCR  = 5'd0;   // Program counter
	localparam logic [REG_IDX_W-1:0] SYSREG_SPR  = 5'd1;   // Stack pointer
	localparam logic [REG_IDX_W-1:0] SYSREG_PDTR = 5'd2;   // Page directory base
	localparam logic [REG_IDX_W-1:0] SYSREG_TISR = 5'd3;   // Task info base
	localparam logic [REG_IDX_W-1:0] SYSREG_TIDR = 5'd4;   // Task id
	localparam logic [REG_IDX_W-1:0] SYSREG_SSR0 = 5'd8;   // Scratch, saved PDTR
	localparam logic [REG_IDX_W-1:0] SYSREG_SSR1 = 5'd9;   // Scratch, saved SPR
	localparam logic [REG_IDX_W-1:0] SYSREG_SSR2 = 5'd10;  // Scratch, saved PCR

	// One decoded micro-op, MSB first
	typedef struct packed {
		logic                  decode_error;  // Bad entry, all else zero
		logic                  commit_wait;   // Issue only after older ops commit
		logic [COND_W-1:0]     cond;          // Condition code
		logic [REG_IDX_W-1:0]  src0;          // Source 0 register
		logic [SRC1_W-1:0]     src1;          // Immediate or register number
		logic                  src1_imm;      // src1 holds an immediate
		logic                  src0_active;
		logic                  src1_active;
		logic                  src0_sys;      // src0 is a system register
		logic                  src1_sys;      // src1 is a system register
		logic                  src0_rename;
		logic                  src1_rename;
		logic [REG_IDX_W-1:0]  dest;          // Destination register
		logic                  wb_en;         // Result is written back
		logic                  use_flag;      // Reads or writes flags
		logic                  dest_sys;      // Destination is a system register
		logic                  dest_rename;   // Destination goes through rename
		exe_cmd_e              cmd;           // Unit command
		exe_unit_e             unit;          // Target execute unit
	} uop_t;

endpackage

// File: dv/ctx_load_cases.txt
// select code0 code1, all hex; code0 is entry 2*select, code1 is entry 2*select+1
// Micro-ops are 67 bits, decode_error at bit 66 down to unit at bits 2:0
0 20300000000500900 0000000010CE00909
1 20400000000501900 00100000090E01912
2 00000000001600909 00000000000401A1B
3 00000000001288B24 00000000001289B24
4 0000000000128AB24 0000000000129F924
5 0000000000129E924 0000000000129D924
6 0000000000129C924 0000000000129B924
7 0000000000129A924 00000000001299924
8 00000000001298924 00000000001297924
9 00000000001296924 00000000001295924
a 00000000001294924 00000000001293924
b 00000000001292924 00000000001291924
c 00000000001290924 0000000000128F924
d 0000000000128E924 0000000000128D924
e 0000000000128C924 0000000000128B924
f 0000000000128A924 00000000001289924
10 00000000001288924 00000000001287924
11 00000000001286924 00000000001285924
12 00000000001284924 00000000001283924
13 00000000001282924 00000000001281924
14 00000000001280924 20800000000502A00
15 00900000000501A1B 1E00000000A28022D
16 40000000000000000 40000000000000000
17 40000000000000000 40000000000000000
15 00900000000501A1B 1E00000000A28022D
40 40000000000000000 40000000000000000
0 20300000000500900 0000000010CE00909
100 40000000000000000 40000000000000000
80000000 40000000000000000 40000000000000000
2 00000000001600909 00000000000401A1B
ffffffff 40000000000000000 40000000000000000
14 00000000001280924 20800000000502A00
7f 40000000000000000 40000000000000000
1 20400000000501900 00100000090E01912

// File: dv/ctx_load_checker.sv
`timescale 1ns/100ps

module ctx_load_checker
	import uop_pkg::*, ctx_load_pkg::*;
(
	input logic             clk,
	input logic             arst_n,
	input logic [SEL_W-1:0] select,  // Pair index into the DUT
	input uop_t             code0,   // Registered even entry
	input uop_t             code1    // Registered odd entry
);

	int unsigned fail_count = 0;  // Failed assertions so far

	// Outputs fully driven once out of reset
	a_no_unknown: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({code0, code1}))
		else
		begin
			fail_count++;
			$error("code0 or code1 holds unknown bits after reset");
		end

	// Error flag follows the select sampled one edge earlier
	a_decode_error: assert property (@(posedge clk) disable iff (!arst_n)
		$past(arst_n) |->
			(code0.decode_error == $past(select >= SEL_W'(CTX_LOAD_PAIRS))) &&
			(code1.decode_error == $past(select >= SEL_W'(CTX_LOAD_PAIRS))))
		else
		begin
			fail_count++;
			$error("decode_error does not match the previous select range");
		end

	// Cleared outputs while reset is low
	a_reset_clear: assert property (@(posedge clk)
		!arst_n |-> (code0 == '0) && (code1 == '0))
		else
		begin
			fail_count++;
			$error("code0 or code1 is not zero during reset");
		end

endmodule

bind ctx_load_microcode ctx_load_checker u_checker (.*);

// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk  // Free running testbench clock
);

	localparam int HALF_PERIOD = 20;  // 40 ns period

	initial
	begin
		clk = 1'b0;  // First rising edge at 20 ns
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

// File: dv/tb_ctx_load.sv
`timescale 1ns/100ps

module tb_ctx_load
	import uop_pkg::*, ctx_load_pkg::*;
();

	localparam int    CLK_PERIOD   = 40;     // ns
	localparam int    RESET_CYCLES = 4;
	localparam int    DRIVE_DELAY  = 2;      // ns after the rising edge
	localparam int    RANDOM_CASES = 8;      // Out of range selects
	localparam int    SEED_INIT    = 65980;
	localparam int    UOP_W        = $bits(uop_t);
	localparam string CASE_FILE    = "dv/ctx_load_cases.txt";

	logic             clk;
	logic             arst_n;
	logic [SEL_W-1:0] select;
	uop_t             code0;
	uop_t             code1;

	logic [SEL_W-1:0] sel_q[$];  // Drive order
	uop_t             exp0_q[$];
	uop_t             exp1_q[$];
	integer           seed;
	int               checks;
	int               errors;

	tb_clock_gen u_clk_gen (
		.clk (clk)
	);

	ctx_load_microcode UUT (
		.clk    (clk),
		.arst_n (arst_n),
		.select (select),
		.code0  (code0),
		.code1  (code1)
	);

	// Bad entry: decode_error only
	function automatic uop_t error_uop();
		uop_t u;
		u = '0;
		u.decode_error = 1'b1;
		return u;
	endfunction

	task automatic load_cases();
		int               fd;
		int               fields;
		string            line;
		logic [SEL_W-1:0] sel;
		logic [UOP_W-1:0] e0;
		logic [UOP_W-1:0] e1;
		begin
			fd = $fopen(CASE_FILE, "r");
			if (fd == 0)
			begin
				$display("Could not open the case file %s", CASE_FILE);
				$display("TESTS FAILED");
				$finish;
			end
			else
			begin
				while ($fgets(line, fd) != 0)
				begin
					fields = $sscanf(line, "%h %h %h", sel, e0, e1);  // Comment lines give 0
					if (fields == 3)
					begin
						sel_q.push_back(sel);
						exp0_q.push_back(uop_t'(e0));
						exp1_q.push_back(uop_t'(e1));
					end
				end
				$fclose(fd);
			end
		end
	endtask

	task automatic add_random_cases();
		logic [SEL_W-1:0] sel;
		begin
			for (int k = 0; k < RANDOM_CASES; k++)
			begin
				sel = $random(seed);
				if (sel < SEL_W'(CTX_LOAD_PAIRS))
					sel = sel + SEL_W'(CTX_LOAD_PAIRS);  // Push past the last pair
				sel_q.push_back(sel);
				exp0_q.push_back(error_uop());
				exp1_q.push_back(error_uop());
			end
		end
	endtask

	// n rising edges, bounded by a watchdog branch
	task automatic wait_cycles(input int n);
		int seen;
		begin
			seen = 0;
			fork
				while (seen < n)
				begin
					@(posedge clk);
					seen++;
				end
				begin
					#(CLK_PERIOD * (n + 1));
					$display("Timeout: clock stopped while waiting for %0d edges", n);
					$display("Checks: %0d, errors: %0d", checks, errors);
					$display("TESTS FAILED");
					$finish;
				end
			join_any
			disable fork;
		end
	endtask

	task automatic check_zero(input string tag);
		begin
			checks = checks + 1;
			assert (code0 === '0 && code1 === '0)
			else
			begin
				errors++;
				$display("ERR %0t ns: outputs not zero %s, code0 %h code1 %h",
					$time, tag, code0, code1);
			end
		end
	endtask

	task automatic check_pair(input logic [SEL_W-1:0] sel, input uop_t exp0, input uop_t exp1);
		begin
			checks = checks + 2;
			assert (code0 === exp0)
			else
			begin
				errors++;
				$display("ERR %0t ns: select %0h code0 %h, expected %h", $time, sel, code0, exp0);
			end
			assert (code1 === exp1)
			else
			begin
				errors++;
				$display("ERR %0t ns: select %0h code1 %h, expected %h", $time, sel, code1, exp1);
			end
		end
	endtask

	initial
	begin
		seed   = SEED_INIT;
		checks = 0;
		errors = 0;
		arst_n = 1'b1;  // Idle until the reset edge
		select = '0;
		load_cases();
		if (sel_q.size() == 0)
		begin
			errors++;
			$display("No cases were read from %s", CASE_FILE);
		end
		add_random_cases();

		#(DRIVE_DELAY);
		arst_n = 1'b0;  // Async clear of the output registers
		wait_cycles(RESET_CYCLES);
		#(DRIVE_DELAY);
		check_zero("during reset");
		arst_n = 1'b1;
		#(DRIVE_DELAY);
		check_zero("after reset release");  // Nothing sampled yet

		// Back to back: drive case i, check case i-1
		for (int i = 0; i <= sel_q.size(); i++)
		begin
			wait_cycles(1);
			#(DRIVE_DELAY);
			if (i > 0)
				check_pair(sel_q[i-1], exp0_q[i-1], exp1_q[i-1]);
			if (i < sel_q.size())
				select = sel_q[i];
		end

		errors = errors + int'(UUT.u_checker.fail_count);  // Bound assertion failures
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
